// ==== logic/arch_pkg.sv ====
package arch_pkg;

  // Data path
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;

  // Defaults for the top level, overridable per instance
  localparam int ROB_ENTRIES = 8;
  localparam int ROB_IDX_W   = 3;
  localparam int MUL_STAGES  = 5;

endpackage

// ==== logic/isa_pkg.sv ====
package isa_pkg;

  // One instruction word, read as R-type or I-type
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
  } instr_u;

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  localparam logic [6:0] F7_BASE   = 7'b0000000;
  localparam logic [6:0] F7_SUB    = 7'b0100000;
  localparam logic [6:0] F7_MULDIV = 7'b0000001;

  // ADD, SUB, ADDI and MUL all share funct3 000
  localparam logic [2:0] F3_ADD_MUL = 3'b000;

  typedef enum logic [0:0] {
    ALU_ADD = 1'b0,
    ALU_SUB = 1'b1
  } alu_op_t;

endpackage

// ==== logic/register_file.sv ====
`timescale 1ns/1ps

module register_file
  import arch_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic [REG_ADDR_W-1:0] rd_addr_a_i,
  input  logic [REG_ADDR_W-1:0] rd_addr_b_i,
  input  logic                  wr_en_i,
  input  logic [REG_ADDR_W-1:0] wr_addr_i,
  input  logic [XLEN-1:0]       wr_data_i,
  output logic [XLEN-1:0]       rd_data_a_o,
  output logic [XLEN-1:0]       rd_data_b_o
);

  logic [XLEN-1:0] regs_q [NUM_REGS];

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      for (int r = 0; r < NUM_REGS; r++) begin
        regs_q[r] <= '0;
      end
    end else if (wr_en_i && wr_addr_i != '0) begin
      regs_q[wr_addr_i] <= wr_data_i;
    end
  end

  assign rd_data_a_o = (rd_addr_a_i == '0) ? '0 : regs_q[rd_addr_a_i];
  assign rd_data_b_o = (rd_addr_b_i == '0) ? '0 : regs_q[rd_addr_b_i];

endmodule

// ==== logic/alu_stage.sv ====
`timescale 1ns/1ps

module alu_stage
  import arch_pkg::*;
  import isa_pkg::*;
#(
  parameter int ROB_IDX_W = arch_pkg::ROB_IDX_W
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  issue_i,
  input  alu_op_t               op_i,
  input  logic [XLEN-1:0]       op_a_i,
  input  logic [XLEN-1:0]       op_b_i,
  input  logic [ROB_IDX_W-1:0]  tag_i,
  input  logic [REG_ADDR_W-1:0] rd_i,
  input  logic                  grant_i,
  output logic                  done_o,
  output logic [ROB_IDX_W-1:0]  tag_o,
  output logic [REG_ADDR_W-1:0] rd_o,
  output logic [XLEN-1:0]       result_o,
  output logic                  hold_o
);

  logic                  held_q;
  logic [XLEN-1:0]       result_q;
  logic [ROB_IDX_W-1:0]  tag_q;
  logic [REG_ADDR_W-1:0] rd_q;
  logic [XLEN-1:0]       sum;

  assign sum = (op_i == ALU_SUB) ? op_a_i - op_b_i : op_a_i + op_b_i;

  // Fresh result goes out directly, a refused one from the result register
  assign done_o   = issue_i || held_q;
  assign result_o = held_q ? result_q : sum;
  assign tag_o    = held_q ? tag_q : tag_i;
  assign rd_o     = held_q ? rd_q : rd_i;
  assign hold_o   = done_o && !grant_i;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      held_q <= 1'b0;
    end else begin
      held_q <= hold_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue_i) begin
      result_q <= sum;
      tag_q    <= tag_i;
      rd_q     <= rd_i;
    end
  end

  a_no_issue_while_held : assert property (@(posedge clk_i) disable iff (!rst_i)
    held_q |-> !issue_i)
    else $error("alu_stage: new op dispatched over a held result");

endmodule

// ==== logic/mul_pipe.sv ====
`timescale 1ns/1ps

module mul_pipe
  import arch_pkg::*;
#(
  parameter int MUL_STAGES = arch_pkg::MUL_STAGES,
  parameter int ROB_IDX_W  = arch_pkg::ROB_IDX_W
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  issue_i,
  input  logic [XLEN-1:0]       op_a_i,
  input  logic [XLEN-1:0]       op_b_i,
  input  logic [ROB_IDX_W-1:0]  tag_i,
  input  logic [REG_ADDR_W-1:0] rd_i,
  output logic                  done_o,
  output logic [ROB_IDX_W-1:0]  tag_o,
  output logic [REG_ADDR_W-1:0] rd_o,
  output logic [XLEN-1:0]       result_o
);

  logic [MUL_STAGES-1:0] valid_q;
  logic [XLEN-1:0]       prod_q [MUL_STAGES];
  logic [ROB_IDX_W-1:0]  tag_q  [MUL_STAGES];
  logic [REG_ADDR_W-1:0] rd_q   [MUL_STAGES];
  logic [XLEN-1:0]       product;

  // Low word is the same for signed and unsigned operands
  assign product = op_a_i * op_b_i;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      valid_q <= '0;
    end else begin
      valid_q[0] <= issue_i;
      for (int s = 1; s < MUL_STAGES; s++) begin
        valid_q[s] <= valid_q[s-1];
      end
    end
  end

  // Plain shift chain, left for retiming to balance
  always_ff @(posedge clk_i) begin
    prod_q[0] <= product;
    tag_q[0]  <= tag_i;
    rd_q[0]   <= rd_i;
    for (int s = 1; s < MUL_STAGES; s++) begin
      prod_q[s] <= prod_q[s-1];
      tag_q[s]  <= tag_q[s-1];
      rd_q[s]   <= rd_q[s-1];
    end
  end

  assign done_o   = valid_q[MUL_STAGES-1];
  assign tag_o    = tag_q[MUL_STAGES-1];
  assign rd_o     = rd_q[MUL_STAGES-1];
  assign result_o = prod_q[MUL_STAGES-1];

endmodule

// ==== logic/wb_arbiter.sv ====
`timescale 1ns/1ps

module wb_arbiter
  import arch_pkg::*;
#(
  parameter int ROB_IDX_W = arch_pkg::ROB_IDX_W
) (
  input  logic                  mul_done_i,
  input  logic [ROB_IDX_W-1:0]  mul_tag_i,
  input  logic [REG_ADDR_W-1:0] mul_rd_i,
  input  logic [XLEN-1:0]       mul_result_i,
  input  logic                  alu_done_i,
  input  logic [ROB_IDX_W-1:0]  alu_tag_i,
  input  logic [REG_ADDR_W-1:0] alu_rd_i,
  input  logic [XLEN-1:0]       alu_result_i,
  output logic                  alu_grant_o,
  output logic                  wb_valid_o,
  output logic [ROB_IDX_W-1:0]  wb_tag_o,
  output logic [REG_ADDR_W-1:0] wb_rd_o,
  output logic [XLEN-1:0]       wb_data_o
);

  // Multiplier cannot stall, so it always wins the port
  always_comb begin
    alu_grant_o = !mul_done_i;
    wb_valid_o  = mul_done_i || alu_done_i;
    if (mul_done_i) begin
      wb_tag_o  = mul_tag_i;
      wb_rd_o   = mul_rd_i;
      wb_data_o = mul_result_i;
    end else begin
      wb_tag_o  = alu_tag_i;
      wb_rd_o   = alu_rd_i;
      wb_data_o = alu_result_i;
    end
  end

endmodule

// ==== logic/reorder_buffer.sv ====
`timescale 1ns/1ps

module reorder_buffer
  import arch_pkg::*;
#(
  parameter int ROB_ENTRIES = arch_pkg::ROB_ENTRIES,
  parameter int ROB_IDX_W   = arch_pkg::ROB_IDX_W
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  alloc_i,
  input  logic [REG_ADDR_W-1:0] alloc_rd_i,
  input  logic                  complete_i,
  input  logic [ROB_IDX_W-1:0]  complete_tag_i,
  input  logic [XLEN-1:0]       complete_data_i,
  output logic                  full_o,
  output logic [ROB_IDX_W-1:0]  alloc_tag_o,
  output logic                  commit_valid_o,
  output logic [REG_ADDR_W-1:0] commit_rd_o,
  output logic [XLEN-1:0]       commit_data_o
);

  logic [ROB_ENTRIES-1:0] valid_q;
  logic [ROB_ENTRIES-1:0] done_q;
  logic [REG_ADDR_W-1:0]  rd_q   [ROB_ENTRIES];
  logic [XLEN-1:0]        data_q [ROB_ENTRIES];
  logic [ROB_IDX_W-1:0]   head_q, tail_q;
  logic [ROB_IDX_W:0]     count_q;
  logic                   commit;

  // Wraps for depths that are not a power of two
  function automatic logic [ROB_IDX_W-1:0] next_idx(input logic [ROB_IDX_W-1:0] idx);
    if (idx == ROB_IDX_W'(ROB_ENTRIES - 1)) begin
      return '0;
    end
    return idx + 1'b1;
  endfunction

  assign full_o      = count_q == (ROB_IDX_W+1)'(ROB_ENTRIES);
  assign alloc_tag_o = tail_q;

  assign commit         = valid_q[head_q] && done_q[head_q];
  assign commit_valid_o = commit;
  assign commit_rd_o    = rd_q[head_q];
  assign commit_data_o  = data_q[head_q];

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      valid_q <= '0;
      done_q  <= '0;
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      if (alloc_i) begin
        valid_q[tail_q] <= 1'b1;
        done_q[tail_q]  <= 1'b0;
        tail_q          <= next_idx(tail_q);
      end
      if (complete_i) begin
        done_q[complete_tag_i] <= 1'b1;
      end
      if (commit) begin
        valid_q[head_q] <= 1'b0;
        head_q          <= next_idx(head_q);
      end
      case ({alloc_i, commit})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (alloc_i) begin
      rd_q[tail_q] <= alloc_rd_i;
    end
    if (complete_i) begin
      data_q[complete_tag_i] <= complete_data_i;
    end
  end

  a_no_alloc_when_full : assert property (@(posedge clk_i) disable iff (!rst_i)
    alloc_i |-> !full_o)
    else $error("reorder_buffer: allocation while full");

  a_complete_live_entry : assert property (@(posedge clk_i) disable iff (!rst_i)
    complete_i |-> valid_q[complete_tag_i] && !done_q[complete_tag_i])
    else $error("reorder_buffer: completion for free entry %0d", complete_tag_i);

endmodule

// ==== logic/issue_stage.sv ====
`timescale 1ns/1ps

module issue_stage
  import arch_pkg::*;
  import isa_pkg::*;
#(
  parameter int ROB_IDX_W = arch_pkg::ROB_IDX_W
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  instr_valid_i,
  input  instr_u                instr_i,
  input  logic [XLEN-1:0]       rs1_data_i,
  input  logic [XLEN-1:0]       rs2_data_i,
  input  logic                  rob_full_i,
  input  logic [ROB_IDX_W-1:0]  rob_tag_i,
  input  logic                  alu_hold_i,
  input  logic                  wb_valid_i,
  input  logic [REG_ADDR_W-1:0] wb_rd_i,
  output logic                  instr_ready_o,
  output logic [REG_ADDR_W-1:0] rs1_addr_o,
  output logic [REG_ADDR_W-1:0] rs2_addr_o,
  output logic                  alloc_o,
  output logic [REG_ADDR_W-1:0] alloc_rd_o,
  output logic                  alu_issue_o,
  output alu_op_t               alu_op_o,
  output logic                  mul_issue_o,
  output logic [XLEN-1:0]       op_a_o,
  output logic [XLEN-1:0]       op_b_o,
  output logic [ROB_IDX_W-1:0]  issue_tag_o,
  output logic [REG_ADDR_W-1:0] issue_rd_o
);

  // One bit per register with a write in flight
  logic [NUM_REGS-1:0]   pending_q;
  logic                  ready_en_q;
  logic                  is_op, is_op_imm;
  logic                  is_alu, is_mul, is_supported;
  logic [REG_ADDR_W-1:0] rd;
  logic [XLEN-1:0]       imm_sext;
  logic                  hazard;
  logic                  accept;

  assign is_op     = instr_i.r.opcode == OPC_OP;
  assign is_op_imm = instr_i.i.opcode == OPC_OP_IMM;
  assign is_mul    = is_op && instr_i.r.funct3 == F3_ADD_MUL && instr_i.r.funct7 == F7_MULDIV;
  assign is_alu    = (is_op && instr_i.r.funct3 == F3_ADD_MUL &&
                      (instr_i.r.funct7 == F7_BASE || instr_i.r.funct7 == F7_SUB)) ||
                     (is_op_imm && instr_i.i.funct3 == F3_ADD_MUL);
  assign is_supported = is_alu || is_mul;

  assign rd         = instr_i.r.rd;
  assign rs1_addr_o = instr_i.r.rs1;
  assign rs2_addr_o = instr_i.r.rs2;
  assign imm_sext   = {{(XLEN-12){instr_i.i.imm12[11]}}, instr_i.i.imm12};

  // For ADDI the rs2 field is immediate bits, so it is not checked
  assign hazard = pending_q[instr_i.r.rs1] || (is_op && pending_q[instr_i.r.rs2]) ||
                  pending_q[rd];

  assign instr_ready_o = ready_en_q && !rob_full_i && !hazard && !(is_alu && alu_hold_i);
  assign accept        = instr_valid_i && instr_ready_o;
  assign alloc_o       = accept;
  assign alloc_rd_o    = rd;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      ready_en_q  <= 1'b0;
      alu_issue_o <= 1'b0;
      mul_issue_o <= 1'b0;
    end else begin
      ready_en_q  <= 1'b1;
      alu_issue_o <= accept && is_alu;
      mul_issue_o <= accept && is_mul;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      alu_op_o    <= (is_op && instr_i.r.funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
      op_a_o      <= rs1_data_i;
      op_b_o      <= is_op ? rs2_data_i : imm_sext;
      issue_tag_o <= rob_tag_i;
      issue_rd_o  <= rd;
    end
  end

  // A new claim overrides a release of the same register
  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      pending_q <= '0;
    end else begin
      if (wb_valid_i) begin
        pending_q[wb_rd_i] <= 1'b0;
      end
      if (accept && rd != '0) begin
        pending_q[rd] <= 1'b1;
      end
    end
  end

  a_supported_only : assert property (@(posedge clk_i) disable iff (!rst_i)
    accept |-> is_supported)
    else $error("issue_stage: unsupported encoding %h accepted", instr_i);

endmodule

// ==== logic/backend_top.sv ====
`timescale 1ns/1ps

module backend_top
  import arch_pkg::*;
  import isa_pkg::*;
#(
  parameter int ROB_ENTRIES = arch_pkg::ROB_ENTRIES,
  parameter int ROB_IDX_W   = arch_pkg::ROB_IDX_W,
  parameter int MUL_STAGES  = arch_pkg::MUL_STAGES
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  instr_valid_i,
  input  instr_u                instr_i,
  output logic                  instr_ready_o,
  output logic                  commit_valid_o,
  output logic [REG_ADDR_W-1:0] commit_rd_o,
  output logic [XLEN-1:0]       commit_data_o
);

  // Issue to execute
  logic [REG_ADDR_W-1:0] rs1_addr, rs2_addr;
  logic [XLEN-1:0]       rs1_data, rs2_data;
  logic                  alloc;
  logic [REG_ADDR_W-1:0] alloc_rd;
  logic                  alu_issue, mul_issue;
  alu_op_t               alu_op;
  logic [XLEN-1:0]       op_a, op_b;
  logic [ROB_IDX_W-1:0]  issue_tag;
  logic [REG_ADDR_W-1:0] issue_rd;

  // Execute to write-back
  logic                  alu_done, alu_hold, alu_grant;
  logic [ROB_IDX_W-1:0]  alu_tag;
  logic [REG_ADDR_W-1:0] alu_rd;
  logic [XLEN-1:0]       alu_result;
  logic                  mul_done;
  logic [ROB_IDX_W-1:0]  mul_tag;
  logic [REG_ADDR_W-1:0] mul_rd;
  logic [XLEN-1:0]       mul_result;

  // Write-back bus and ROB status
  logic                  wb_valid;
  logic [ROB_IDX_W-1:0]  wb_tag;
  logic [REG_ADDR_W-1:0] wb_rd;
  logic [XLEN-1:0]       wb_data;
  logic                  rob_full;
  logic [ROB_IDX_W-1:0]  rob_tag;

  issue_stage #(
    .ROB_IDX_W     (ROB_IDX_W)
  ) issue_stage_inst (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .rs1_data_i    (rs1_data),
    .rs2_data_i    (rs2_data),
    .rob_full_i    (rob_full),
    .rob_tag_i     (rob_tag),
    .alu_hold_i    (alu_hold),
    .wb_valid_i    (wb_valid),
    .wb_rd_i       (wb_rd),
    .instr_ready_o (instr_ready_o),
    .rs1_addr_o    (rs1_addr),
    .rs2_addr_o    (rs2_addr),
    .alloc_o       (alloc),
    .alloc_rd_o    (alloc_rd),
    .alu_issue_o   (alu_issue),
    .alu_op_o      (alu_op),
    .mul_issue_o   (mul_issue),
    .op_a_o        (op_a),
    .op_b_o        (op_b),
    .issue_tag_o   (issue_tag),
    .issue_rd_o    (issue_rd)
  );

  alu_stage #(
    .ROB_IDX_W (ROB_IDX_W)
  ) alu_stage_inst (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .issue_i   (alu_issue),
    .op_i      (alu_op),
    .op_a_i    (op_a),
    .op_b_i    (op_b),
    .tag_i     (issue_tag),
    .rd_i      (issue_rd),
    .grant_i   (alu_grant),
    .done_o    (alu_done),
    .tag_o     (alu_tag),
    .rd_o      (alu_rd),
    .result_o  (alu_result),
    .hold_o    (alu_hold)
  );

  mul_pipe #(
    .MUL_STAGES (MUL_STAGES),
    .ROB_IDX_W  (ROB_IDX_W)
  ) mul_pipe_inst (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .issue_i    (mul_issue),
    .op_a_i     (op_a),
    .op_b_i     (op_b),
    .tag_i      (issue_tag),
    .rd_i       (issue_rd),
    .done_o     (mul_done),
    .tag_o      (mul_tag),
    .rd_o       (mul_rd),
    .result_o   (mul_result)
  );

  wb_arbiter #(
    .ROB_IDX_W    (ROB_IDX_W)
  ) wb_arbiter_inst (
    .mul_done_i   (mul_done),
    .mul_tag_i    (mul_tag),
    .mul_rd_i     (mul_rd),
    .mul_result_i (mul_result),
    .alu_done_i   (alu_done),
    .alu_tag_i    (alu_tag),
    .alu_rd_i     (alu_rd),
    .alu_result_i (alu_result),
    .alu_grant_o  (alu_grant),
    .wb_valid_o   (wb_valid),
    .wb_tag_o     (wb_tag),
    .wb_rd_o      (wb_rd),
    .wb_data_o    (wb_data)
  );

  register_file future_file_inst (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .rd_addr_a_i (rs1_addr),
    .rd_addr_b_i (rs2_addr),
    .wr_en_i     (wb_valid),
    .wr_addr_i   (wb_rd),
    .wr_data_i   (wb_data),
    .rd_data_a_o (rs1_data),
    .rd_data_b_o (rs2_data)
  );

  reorder_buffer #(
    .ROB_ENTRIES     (ROB_ENTRIES),
    .ROB_IDX_W       (ROB_IDX_W)
  ) reorder_buffer_inst (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .alloc_i         (alloc),
    .alloc_rd_i      (alloc_rd),
    .complete_i      (wb_valid),
    .complete_tag_i  (wb_tag),
    .complete_data_i (wb_data),
    .full_o          (rob_full),
    .alloc_tag_o     (rob_tag),
    .commit_valid_o  (commit_valid_o),
    .commit_rd_o     (commit_rd_o),
    .commit_data_o   (commit_data_o)
  );

endmodule

// ==== sim/tb_rv_backend.sv ====
`timescale 1ns/1ps

module tb_rv_backend
  import arch_pkg::*;
  import isa_pkg::*;
();

  localparam int READY_TIMEOUT = 200;
  localparam int DRAIN_TIMEOUT = 500;
  localparam int RANDOM_COUNT  = 400;

  logic                  clk_i;
  logic                  rst_i;
  logic                  instr_valid_i;
  instr_u                instr_i;
  logic                  instr_ready_o;
  logic                  commit_valid_o;
  logic [REG_ADDR_W-1:0] commit_rd_o;
  logic [XLEN-1:0]       commit_data_o;

  logic [31:0]           rng_state;
  logic [XLEN-1:0]       model_regs [NUM_REGS];
  logic [REG_ADDR_W-1:0] exp_rd_q [$];
  logic [XLEN-1:0]       exp_data_q [$];

  backend_top #(
    .ROB_ENTRIES    (ROB_ENTRIES),
    .ROB_IDX_W      (ROB_IDX_W),
    .MUL_STAGES     (MUL_STAGES)
  ) backend_top_inst (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .instr_valid_i  (instr_valid_i),
    .instr_i        (instr_i),
    .instr_ready_o  (instr_ready_o),
    .commit_valid_o (commit_valid_o),
    .commit_rd_o    (commit_rd_o),
    .commit_data_o  (commit_data_o)
  );

  always #5 clk_i = ~clk_i;

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = lcg_step(rng_state);
    return rng_state;
  endfunction

  function automatic instr_u enc_r(input logic [6:0] f7, input logic [4:0] rd,
                                   input logic [4:0] rs1, input logic [4:0] rs2);
    instr_u w;
    w.r.funct7 = f7;
    w.r.rs2    = rs2;
    w.r.rs1    = rs1;
    w.r.funct3 = F3_ADD_MUL;
    w.r.rd     = rd;
    w.r.opcode = OPC_OP;
    return w;
  endfunction

  function automatic instr_u enc_i(input logic [4:0] rd, input logic [4:0] rs1, input int imm);
    instr_u w;
    w.i.imm12  = imm[11:0];
    w.i.rs1    = rs1;
    w.i.funct3 = F3_ADD_MUL;
    w.i.rd     = rd;
    w.i.opcode = OPC_OP_IMM;
    return w;
  endfunction

  // Runs the ISA in order on the model file
  // A write to x0 still commits its computed value
  function automatic logic [XLEN-1:0] ref_execute(input instr_u w);
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] res;
    a = model_regs[w.r.rs1];
    b = model_regs[w.r.rs2];
    if (w.i.opcode == OPC_OP_IMM) begin
      res = a + {{(XLEN-12){w.i.imm12[11]}}, w.i.imm12};
    end else if (w.r.funct7 == F7_SUB) begin
      res = a - b;
    end else if (w.r.funct7 == F7_MULDIV) begin
      res = a * b;
    end else begin
      res = a + b;
    end
    if (w.r.rd != 5'd0) begin
      model_regs[w.r.rd] = res;
    end
    return res;
  endfunction

  task automatic fail_with(input string reason);
    $display("%s", reason);
    $display("Done: errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    fail_with($sformatf("mismatch at %0t: %s expected 0x%08h, actual 0x%08h",
                        $time, name, expected, actual));
  endtask

  // Starts and ends 1 ns after a rising edge
  task automatic send_instr(input instr_u w);
    int waited;
    waited = 0;
    instr_i       = w;
    instr_valid_i = 1'b1;
    @(negedge clk_i);
    while (instr_ready_o !== 1'b1) begin
      waited++;
      if (waited > READY_TIMEOUT) begin
        fail_with($sformatf("instruction %h was never accepted", w));
      end
      @(negedge clk_i);
    end
    @(posedge clk_i);
    exp_data_q.push_back(ref_execute(w));
    exp_rd_q.push_back(w.r.rd);
    #1;
    instr_valid_i = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    instr_valid_i = 1'b0;
    repeat (n) @(posedge clk_i);
    #1;
  endtask

  // Checker compares each commit with the oldest expected result
  always @(negedge clk_i) begin
    logic [REG_ADDR_W-1:0] exp_rd;
    logic [XLEN-1:0]       exp_data;
    if (rst_i === 1'b1 && commit_valid_o === 1'b1) begin
      if (exp_rd_q.size() == 0) begin
        fail_with($sformatf("commit at %0t with no instruction outstanding", $time));
      end
      exp_rd   = exp_rd_q.pop_front();
      exp_data = exp_data_q.pop_front();
      assert (commit_rd_o == exp_rd)
        else report_mismatch("commit_rd_o", {27'd0, exp_rd}, {27'd0, commit_rd_o});
      assert (commit_data_o == exp_data)
        else report_mismatch("commit_data_o", exp_data, commit_data_o);
    end
  end

  initial begin
    logic [31:0] rnd;
    int          waited;
    clk_i           = 1'b0;
    rst_i           = 1'b0;
    instr_valid_i   = 1'b0;
    instr_i         = '0;
    rng_state       = 32'h5110_6f59;
    for (int r = 0; r < NUM_REGS; r++) begin
      model_regs[r] = '0;
    end
    repeat (3) @(posedge clk_i);
    #1;
    rst_i = 1'b1;

    // Plain ALU ops with negative immediates
    send_instr(enc_i(5'd1, 5'd0, 100));
    send_instr(enc_i(5'd2, 5'd0, -7));
    send_instr(enc_i(5'd3, 5'd0, -2048));
    send_instr(enc_i(5'd4, 5'd0, 2047));
    send_instr(enc_r(F7_BASE, 5'd5, 5'd1, 5'd2));
    send_instr(enc_r(F7_SUB, 5'd6, 5'd2, 5'd1));
    send_instr(enc_i(5'd7, 5'd3, -1));

    // Signed products keep the low word
    send_instr(enc_r(F7_MULDIV, 5'd8, 5'd2, 5'd1));
    send_instr(enc_r(F7_MULDIV, 5'd9, 5'd3, 5'd3));
    send_instr(enc_r(F7_MULDIV, 5'd10, 5'd9, 5'd9));

    // Younger ALU ops finish before the MUL but commit after it
    send_instr(enc_r(F7_MULDIV, 5'd11, 5'd4, 5'd4));
    send_instr(enc_i(5'd12, 5'd1, 33));
    send_instr(enc_r(F7_BASE, 5'd13, 5'd2, 5'd3));
    send_instr(enc_r(F7_SUB, 5'd14, 5'd4, 5'd1));

    // RAW and WAW on x15
    send_instr(enc_i(5'd15, 5'd0, 3));
    send_instr(enc_r(F7_BASE, 5'd15, 5'd15, 5'd15));
    send_instr(enc_r(F7_MULDIV, 5'd15, 5'd15, 5'd15));
    send_instr(enc_i(5'd15, 5'd15, -9));
    send_instr(enc_r(F7_SUB, 5'd16, 5'd15, 5'd2));

    // x0 as destination
    send_instr(enc_i(5'd0, 5'd1, 55));
    send_instr(enc_r(F7_MULDIV, 5'd0, 5'd1, 5'd2));
    send_instr(enc_r(F7_BASE, 5'd17, 5'd0, 5'd0));
    send_instr(enc_i(5'd18, 5'd0, 0));
    idle_cycles(4);

    // Independent burst to fill the ROB and the multiplier
    for (int k = 0; k < 16; k++) begin
      if (k % 3 == 2) begin
        send_instr(enc_r(F7_BASE, 5'(16 + k), 5'(1 + k % 7), 5'(2 + k % 6)));
      end else begin
        send_instr(enc_r(F7_MULDIV, 5'(16 + k), 5'(1 + k % 7), 5'(2 + k % 6)));
      end
    end

    // Dense random stream on x0..x7
    for (int n = 0; n < RANDOM_COUNT; n++) begin
      rnd = next_rand();
      case (rnd[17:16])
        2'd0: send_instr(enc_r(F7_BASE, {2'b00, rnd[20:18]}, {2'b00, rnd[23:21]},
                               {2'b00, rnd[26:24]}));
        2'd1: send_instr(enc_r(F7_SUB, {2'b00, rnd[20:18]}, {2'b00, rnd[23:21]},
                               {2'b00, rnd[26:24]}));
        2'd2: send_instr(enc_i({2'b00, rnd[20:18]}, {2'b00, rnd[23:21]},
                               int'(rnd[11:0])));
        default: send_instr(enc_r(F7_MULDIV, {2'b00, rnd[20:18]}, {2'b00, rnd[23:21]},
                                  {2'b00, rnd[26:24]}));
      endcase
      if (rnd[31:29] == 3'd0) begin
        idle_cycles(1);
      end
    end

    instr_valid_i = 1'b0;
    waited = 0;
    while (exp_rd_q.size() != 0) begin
      waited++;
      if (waited > DRAIN_TIMEOUT) begin
        fail_with($sformatf("%0d instructions never committed", exp_rd_q.size()));
      end
      @(negedge clk_i);
    end
    repeat (10) @(posedge clk_i);

    $display("Done: no errors");
    $finish;
  end

endmodule

// ==== rv_backend.f ====
logic/arch_pkg.sv
logic/isa_pkg.sv
logic/register_file.sv
logic/alu_stage.sv
logic/mul_pipe.sv
logic/wb_arbiter.sv
logic/reorder_buffer.sv
logic/issue_stage.sv
logic/backend_top.sv
sim/tb_rv_backend.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_rv_backend
FILELIST  ?= rv_backend.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Done: no errors
VFLAGS    ?= --binary --timing --assert

SOURCES := $(wildcard logic/*.sv sim/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM_BIN)
	$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
